/* dv/multicore_sva.sv */
`default_nettype none

`include "proc_config.svh"

module multicore_sva (
    input wire logic                                    clk,
    input wire logic                                    reset,
    input wire logic                                    start,
    input wire logic [`NUM_CORES-1:0]                   core_done,
    input wire logic                                    all_done,
    input wire logic [`NUM_CORES*core_pkg::COUNT_W-1:0] core_retired
);

    // violations so far, read back by the testbench
    int unsigned fail_count = 0;

    // summary level follows the per core flags every cycle
    all_done_matches: assert property (@(posedge clk) disable iff (reset)
        all_done == &core_done)
    else begin
        fail_count++;
        $error("all_done is not the AND of core_done");
    end

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
        // done only drops on start
        done_held: assert property (@(posedge clk) disable iff (reset)
            (core_done[i] && !start) |=> core_done[i])
        else begin
            fail_count++;
            $error("core_done[%0d] fell without start", i);
        end

        // a halted core retires nothing
        count_frozen: assert property (@(posedge clk) disable iff (reset)
            (core_done[i] && !start) |=>
                $stable(core_retired[i*core_pkg::COUNT_W +: core_pkg::COUNT_W]))
        else begin
            fail_count++;
            $error("core_retired[%0d] moved while the core was done", i);
        end
    end

endmodule

bind multicore_top multicore_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .core_done    (core_done),
    .all_done     (all_done),
    .core_retired (core_retired)
);

`default_nettype wire

/* dv/multicore_tb.sv */
`default_nettype none

`include "proc_config.svh"

module multicore_tb;

    localparam int DONE_TIMEOUT = 2000;
    localparam int CW = core_pkg::COUNT_W;

    logic                              clk;
    logic                              reset;
    logic                              prog_we;
    isa_pkg::iaddr_t                   prog_addr;
    isa_pkg::word_t                    prog_data;
    logic                              start;
    logic [`NUM_CORES-1:0]             core_done;
    logic                              all_done;
    logic [`NUM_CORES*`WORD_W-1:0]     core_ac;
    logic [`NUM_CORES*CW-1:0]          core_retired;

    // program image, shared by the loader and the model
    isa_pkg::word_t prog [`IMEM_DEPTH];
    int             prog_len;
    logic [31:0]    lfsr;
    int             value_errors;
    int             timeout_errors;
    int             total_errors;

    multicore_top DUT (
        .clk          (clk),
        .reset        (reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .start        (start),
        .core_done    (core_done),
        .all_done     (all_done),
        .core_ac      (core_ac),
        .core_retired (core_retired)
    );

    always #5 clk = ~clk;

    // galois LFSR, one step per bit taken
    function automatic isa_pkg::word_t random_word(input int nbits);
        isa_pkg::word_t w;
        w = '0;
        for (int k = 0; k < nbits; k++) begin
            w = {w[`WORD_W-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return w;
    endfunction

    task automatic put_op(input isa_pkg::opcode_e op);
        prog[prog_len] = isa_pkg::word_t'(op);
        prog_len++;
    endtask

    // opcode followed by its operand word
    task automatic put_op_arg(input isa_pkg::opcode_e op, input isa_pkg::word_t arg);
        put_op(op);
        prog[prog_len] = arg;
        prog_len++;
    endtask

    // instruction set interpreter, one core from address 0
    task automatic model_run(input int id, output isa_pkg::word_t ac_out,
                             output int count_out);
        isa_pkg::word_t ac, r, a, b, c, d, op, arg;
        isa_pkg::word_t dm [`DMEM_DEPTH];
        int pc;
        int count;
        bit halted;
        ac = '0;
        r = '0;
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        foreach (dm[k]) dm[k] = '0;
        pc = 0;
        count = 0;
        halted = 0;
        while (!halted && count < 10000) begin
            op = prog[pc];
            pc = (pc + 1) % `IMEM_DEPTH;
            arg = '0;
            // operand word follows the opcode
            if (op == isa_pkg::LDAC || op == isa_pkg::JUMP ||
                op == isa_pkg::JPNZ || op == isa_pkg::JPPZ) begin
                arg = prog[pc];
                pc = (pc + 1) % `IMEM_DEPTH;
            end
            count++;
            case (op)
                isa_pkg::LDAC:  ac = arg;
                isa_pkg::CLAC:  ac = '0;
                isa_pkg::INAC:  ac = ac + 1;
                isa_pkg::ADD:   ac = ac + r;
                isa_pkg::SUB:   ac = ac - r;
                isa_pkg::MUL:   ac = ac * r;
                isa_pkg::MVCID: ac = isa_pkg::word_t'(id);
                isa_pkg::MVACR: r = ac;
                isa_pkg::MVACA: a = ac;
                isa_pkg::MVACB: b = ac;
                isa_pkg::MVACC: c = ac;
                isa_pkg::MVACD: d = ac;
                isa_pkg::MVA:   ac = a;
                isa_pkg::MVB:   ac = b;
                isa_pkg::MVC:   ac = c;
                isa_pkg::MVD:   ac = d;
                isa_pkg::LDDAC: ac = dm[d % `DMEM_DEPTH];
                isa_pkg::STDAC: dm[d % `DMEM_DEPTH] = ac;
                isa_pkg::JUMP:  pc = arg % `IMEM_DEPTH;
                isa_pkg::JPNZ:  if (ac != 0) pc = arg % `IMEM_DEPTH;
                isa_pkg::JPPZ:  if (!ac[`WORD_W-1]) pc = arg % `IMEM_DEPTH;
                isa_pkg::ENDOP: halted = 1;
                default: ;
            endcase
        end
        ac_out = ac;
        count_out = count;
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got == exp) else begin
            value_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // straight-line arithmetic, two random immediates
    task automatic build_arith();
        prog_len = 0;
        put_op_arg(isa_pkg::LDAC, random_word(16));
        put_op(isa_pkg::MVACR);
        put_op(isa_pkg::MVCID);
        put_op(isa_pkg::ADD);
        put_op(isa_pkg::MVACR);
        put_op_arg(isa_pkg::LDAC, random_word(16));
        put_op(isa_pkg::SUB);
        put_op(isa_pkg::MVACR);
        put_op(isa_pkg::MVCID);
        put_op(isa_pkg::INAC);
        put_op(isa_pkg::MUL);
        put_op(isa_pkg::ENDOP);
    endtask

    // countdown from id+3, addresses in the comments
    task automatic build_branch();
        prog_len = 0;
        put_op_arg(isa_pkg::LDAC, 16'd1);
        put_op(isa_pkg::MVACR);
        put_op(isa_pkg::MVCID);
        put_op(isa_pkg::INAC);
        put_op(isa_pkg::INAC);
        put_op(isa_pkg::INAC);
        // loop at 7
        put_op(isa_pkg::SUB);
        put_op_arg(isa_pkg::JPNZ, 16'd7);
        // 10, AC goes negative so the first JPPZ falls through
        put_op(isa_pkg::SUB);
        put_op_arg(isa_pkg::JPPZ, 16'd16);
        put_op(isa_pkg::INAC);
        // 14, early exit over the poisoned load
        put_op_arg(isa_pkg::JPPZ, 16'd18);
        put_op_arg(isa_pkg::LDAC, random_word(16));
        // 18
        put_op(isa_pkg::MVCID);
        put_op_arg(isa_pkg::JUMP, 16'd23);
        put_op(isa_pkg::CLAC);
        put_op(isa_pkg::CLAC);
        // 23
        put_op(isa_pkg::ADD);
        put_op(isa_pkg::ENDOP);
    endtask

    // id-dependent stores at D=5 and D=9, then read back
    task automatic build_memory();
        prog_len = 0;
        put_op(isa_pkg::MVCID);
        put_op(isa_pkg::MVACR);
        put_op_arg(isa_pkg::LDAC, random_word(16));
        put_op(isa_pkg::ADD);
        put_op(isa_pkg::MVACA);
        put_op_arg(isa_pkg::LDAC, 16'd5);
        put_op(isa_pkg::MVACD);
        put_op(isa_pkg::MVA);
        put_op(isa_pkg::STDAC);
        put_op_arg(isa_pkg::LDAC, random_word(16));
        put_op(isa_pkg::MUL);
        put_op(isa_pkg::MVACB);
        put_op_arg(isa_pkg::LDAC, 16'd9);
        put_op(isa_pkg::MVACD);
        put_op(isa_pkg::MVB);
        put_op(isa_pkg::STDAC);
        put_op(isa_pkg::CLAC);
        put_op(isa_pkg::NOP);
        put_op_arg(isa_pkg::LDAC, 16'd5);
        put_op(isa_pkg::MVACD);
        put_op(isa_pkg::LDDAC);
        put_op(isa_pkg::MVACC);
        put_op_arg(isa_pkg::LDAC, 16'd9);
        put_op(isa_pkg::MVACD);
        put_op(isa_pkg::LDDAC);
        put_op(isa_pkg::MVACR);
        put_op(isa_pkg::MVC);
        put_op(isa_pkg::SUB);
        put_op(isa_pkg::MVACB);
        put_op(isa_pkg::MVD);
        put_op(isa_pkg::MVACR);
        put_op(isa_pkg::MVB);
        put_op(isa_pkg::ADD);
        put_op(isa_pkg::ENDOP);
    endtask

    // one word per cycle through the write port
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= isa_pkg::iaddr_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic wait_all_done();
        int cycles;
        cycles = 0;
        while (!all_done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!all_done) begin
            timeout_errors++;
            $display("timeout: all_done still low after %0d cycles", cycles);
        end
    endtask

    task automatic check_cores();
        isa_pkg::word_t exp_ac;
        int exp_count;
        for (int i = 0; i < `NUM_CORES; i++) begin
            model_run(i, exp_ac, exp_count);
            expect_equal($sformatf("core_ac[%0d]", i),
                         core_ac[i*`WORD_W +: `WORD_W], exp_ac);
            expect_equal($sformatf("core_retired[%0d]", i),
                         core_retired[i*CW +: CW], exp_count);
        end
    endtask

    task automatic run_program();
        load_program();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        // flags from the previous run are gone
        expect_equal("core_done", core_done, '0);
        expect_equal("all_done", all_done, '0);
        wait_all_done();
        check_cores();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        lfsr = 32'd76782;
        value_errors = 0;
        timeout_errors = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // idle state before any start
        expect_equal("core_done", core_done, '0);
        expect_equal("all_done", all_done, '0);
        expect_equal("core_retired", core_retired, '0);
        build_arith();
        run_program();
        build_branch();
        run_program();
        build_memory();
        run_program();
        // restart with fresh immediates
        build_arith();
        run_program();
        // idle tail so the done-level properties get exercised
        repeat (20) @(negedge clk);
        total_errors = value_errors + timeout_errors + DUT.u_sva.fail_count;
        $display("errors: value %0d, timeout %0d, protocol %0d",
                 value_errors, timeout_errors, DUT.u_sva.fail_count);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/core_if.sv
hw/instr_mem.sv
hw/core_decode.sv
hw/core_execute.sv
hw/core_result.sv
hw/multicore_top.sv
dv/multicore_sva.sv
dv/multicore_tb.sv

/* hw/core_decode.sv */
`default_nettype none

`include "proc_config.svh"

module core_decode (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            start,
    // instruction memory read port
    input  wire isa_pkg::word_t  rdata,
    output isa_pkg::iaddr_t      raddr,
    issue_if.decode              iss
);

    core_pkg::seq_state_e state;
    isa_pkg::iaddr_t      pc;
    isa_pkg::opcode_e     op_q;
    isa_pkg::word_t       operand_q;
    // set while the pending read is the operand word
    logic                 opnd_phase;
    logic                 two_word;

    // memory always reads at the pc
    // pc points at the operand word after DECODE of a two word op
    assign raddr = pc;

    // ops that carry a second word
    always_comb begin
        case (op_q)
            isa_pkg::LDAC,
            isa_pkg::JUMP,
            isa_pkg::JPNZ,
            isa_pkg::JPPZ: two_word = 1'b1;
            default:       two_word = 1'b0;
        endcase
    end

    // sequencer and program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= core_pkg::IDLE;
            pc         <= '0;
            opnd_phase <= 1'b0;
        end else if (start) begin
            // restart from address 0, whatever the core was doing
            state      <= core_pkg::FETCH;
            pc         <= '0;
            opnd_phase <= 1'b0;
        end else begin
            case (state)
                core_pkg::FETCH: begin
                    state <= core_pkg::WAIT;
                end
                core_pkg::WAIT: begin
                    // second wait goes straight to execute
                    state      <= opnd_phase ? core_pkg::EXEC : core_pkg::DECODE;
                    opnd_phase <= 1'b0;
                end
                core_pkg::DECODE: begin
                    if (two_word) begin
                        pc    <= pc + 1'b1;
                        state <= core_pkg::OPERAND;
                    end else begin
                        state <= core_pkg::EXEC;
                    end
                end
                core_pkg::OPERAND: begin
                    opnd_phase <= 1'b1;
                    state      <= core_pkg::WAIT;
                end
                core_pkg::EXEC: begin
                    // branch_taken is valid for this op during the issue cycle
                    if (iss.branch_taken) begin
                        pc <= operand_q[isa_pkg::IADDR_W-1:0];
                    end else begin
                        pc <= pc + 1'b1;
                    end
                    if (op_q == isa_pkg::ENDOP) begin
                        state <= core_pkg::HALT;
                    end else begin
                        state <= core_pkg::FETCH;
                    end
                end
                // IDLE and HALT only leave on start
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    // instruction and operand capture, read data is valid in WAIT
    always_ff @(posedge clk) begin
        if (state == core_pkg::WAIT) begin
            if (opnd_phase) begin
                operand_q <= rdata;
            end else begin
                op_q <= isa_pkg::opcode_e'(rdata);
            end
        end
    end

    // one issue per instruction
    assign iss.issue   = (state == core_pkg::EXEC);
    assign iss.op      = op_q;
    assign iss.operand = operand_q;

endmodule

`default_nettype wire

/* hw/core_execute.sv */
`default_nettype none

`include "proc_config.svh"

module core_execute #(
    parameter core_pkg::core_id_t CORE_ID = '0
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    issue_if.execute  iss,
    retire_if.execute ret
);

    // architectural registers
    isa_pkg::word_t ac;
    isa_pkg::word_t r;
    isa_pkg::word_t a;
    isa_pkg::word_t b;
    isa_pkg::word_t c;
    isa_pkg::word_t d;
    isa_pkg::word_t ac_next;

    // private data memory, indexed by D
    isa_pkg::word_t   dmem [`DMEM_DEPTH];
    core_pkg::daddr_t d_idx;

    assign d_idx = d[core_pkg::DADDR_W-1:0];

    // jump decision from AC as it stands at issue
    always_comb begin
        case (iss.op)
            isa_pkg::JUMP: iss.branch_taken = 1'b1;
            isa_pkg::JPNZ: iss.branch_taken = (ac != '0);
            // zero or positive as signed
            isa_pkg::JPPZ: iss.branch_taken = ~ac[`WORD_W-1];
            default:       iss.branch_taken = 1'b0;
        endcase
    end

    // accumulator datapath
    // ADD, SUB and MUL keep the low word only
    always_comb begin
        case (iss.op)
            isa_pkg::LDAC:  ac_next = iss.operand;
            isa_pkg::MVA:   ac_next = a;
            isa_pkg::MVB:   ac_next = b;
            isa_pkg::MVC:   ac_next = c;
            isa_pkg::MVD:   ac_next = d;
            isa_pkg::MVCID: ac_next = isa_pkg::word_t'(CORE_ID);
            isa_pkg::INAC:  ac_next = ac + 1'b1;
            isa_pkg::CLAC:  ac_next = '0;
            isa_pkg::ADD:   ac_next = ac + r;
            isa_pkg::SUB:   ac_next = ac - r;
            isa_pkg::MUL:   ac_next = ac * r;
            isa_pkg::LDDAC: ac_next = dmem[d_idx];
            // moves out of AC, stores, jumps, NOP and ENDOP
            default:        ac_next = ac;
        endcase
    end

    // register file, cleared at every start
    always_ff @(posedge clk) begin
        if (reset || start) begin
            ac <= '0;
            r  <= '0;
            a  <= '0;
            b  <= '0;
            c  <= '0;
            d  <= '0;
        end else if (iss.issue) begin
            ac <= ac_next;
            case (iss.op)
                isa_pkg::MVACR: r <= ac;
                isa_pkg::MVACA: a <= ac;
                isa_pkg::MVACB: b <= ac;
                isa_pkg::MVACC: c <= ac;
                isa_pkg::MVACD: d <= ac;
                default: ;
            endcase
        end
    end

    // store at D, content survives a restart
    always_ff @(posedge clk) begin
        if (iss.issue && (iss.op == isa_pkg::STDAC)) begin
            dmem[d_idx] <= ac;
        end
    end

    // retire one cycle after issue, lines up with the updated AC
    // an issue that meets start belongs to the old run and is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            ret.retire <= 1'b0;
            ret.halt   <= 1'b0;
        end else begin
            ret.retire <= iss.issue && !start;
            ret.halt   <= iss.issue && !start && (iss.op == isa_pkg::ENDOP);
        end
    end

    assign ret.ac = ac;

endmodule

`default_nettype wire

/* hw/core_if.sv */
`default_nettype none

`include "proc_config.svh"

// decode to execute, one instruction at a time
interface issue_if;
    // one cycle strobe, op and operand stable while high
    logic                issue;
    isa_pkg::opcode_e    op;
    isa_pkg::word_t      operand;
    // jump decision from the current AC
    logic                branch_taken;

    modport decode (
        output issue,
        output op,
        output operand,
        input  branch_taken
    );

    modport execute (
        input  issue,
        input  op,
        input  operand,
        output branch_taken
    );
endinterface

// execute to result, per core status
interface retire_if;
    logic           retire;
    logic           halt;
    isa_pkg::word_t ac;

    modport execute (
        output retire,
        output halt,
        output ac
    );

    modport result (
        input retire,
        input halt,
        input ac
    );
endinterface

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

`include "proc_config.svh"

package core_pkg;

    // fetch and decode sequencer
    // WAIT is shared by the opcode and the operand read
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT,
        DECODE,
        OPERAND,
        EXEC,
        HALT
    } seq_state_e;

    // core number, at least one bit even for a single core
    localparam int ID_W = (`NUM_CORES > 1) ? $clog2(`NUM_CORES) : 1;
    typedef logic [ID_W-1:0] core_id_t;

    // retired instruction counter
    localparam int COUNT_W = 16;
    typedef logic [COUNT_W-1:0] count_t;

    // private data memory index, taken from the low bits of D
    localparam int DADDR_W = $clog2(`DMEM_DEPTH);
    typedef logic [DADDR_W-1:0] daddr_t;

endpackage

`default_nettype wire

/* hw/core_result.sv */
`default_nettype none

`include "proc_config.svh"

module core_result (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    retire_if.result  ret [`NUM_CORES],
    output wire logic [`NUM_CORES-1:0]                                  core_done,
    output wire logic                                                   all_done,
    output wire logic [`NUM_CORES*`WORD_W-1:0]                          core_ac,
    output wire logic [`NUM_CORES*core_pkg::COUNT_W-1:0] core_retired
);

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_slot
        logic              done_r;
        core_pkg::count_t  count_r;

        // done latches on ENDOP, held until the next start
        // counter stops by itself since a halted core issues nothing
        always_ff @(posedge clk) begin
            if (reset || start) begin
                done_r  <= 1'b0;
                count_r <= '0;
            end else begin
                if (ret[i].halt) begin
                    done_r <= 1'b1;
                end
                if (ret[i].retire) begin
                    count_r <= count_r + 1'b1;
                end
            end
        end

        // flat per core slices, core 0 in the low bits
        assign core_done[i]                                         = done_r;
        assign core_ac[i*`WORD_W +: `WORD_W]                        = ret[i].ac;
        assign core_retired[i*core_pkg::COUNT_W +: core_pkg::COUNT_W] = count_r;
    end

    // every core has reached ENDOP
    assign all_done = &core_done;

endmodule

`default_nettype wire

/* hw/instr_mem.sv */
`default_nettype none

`include "proc_config.svh"

module instr_mem (
    input  wire logic           clk,
    // program load port
    input  wire logic           we,
    input  wire isa_pkg::iaddr_t waddr,
    input  wire isa_pkg::word_t wdata,
    // one read port per core
    input  wire isa_pkg::iaddr_t raddr [`NUM_CORES],
    output isa_pkg::word_t      rdata [`NUM_CORES]
);

    // program store, shared by all cores
    isa_pkg::word_t mem [`IMEM_DEPTH];

    // single write port, only used while the cores are stopped
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered reads
    // data shows up one cycle after the address
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_CORES; i++) begin
            rdata[i] <= mem[raddr[i]];
        end
    end

endmodule

`default_nettype wire

/* hw/isa_pkg.sv */
`default_nettype none

`include "proc_config.svh"

package isa_pkg;

    // instruction address width from the program store depth
    localparam int IADDR_W = $clog2(`IMEM_DEPTH);

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [IADDR_W-1:0] iaddr_t;

    // opcode numbering follows the legacy accumulator machine
    // LDAC and the three jumps take an extra operand word
    typedef enum logic [`WORD_W-1:0] {
        LDAC  = 5,
        MVACR = 29,
        MVACC = 30,
        MVA   = 31,
        MVB   = 32,
        MVC   = 33,
        INAC  = 34,
        CLAC  = 35,
        ADD   = 36,
        SUB   = 38,
        MUL   = 40,
        JUMP  = 46,
        JPNZ  = 48,
        NOP   = 50,
        ENDOP = 51,
        MVACA = 52,
        MVACB = 53,
        MVACD = 54,
        LDDAC = 55,
        STDAC = 59,
        JPPZ  = 62,
        MVCID = 64,
        MVD   = 65
    } opcode_e;

endpackage

`default_nettype wire

/* hw/multicore_top.sv */
`default_nettype none

`include "proc_config.svh"

module multicore_top (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    // program load
    input  wire logic                                     prog_we,
    input  wire isa_pkg::iaddr_t                          prog_addr,
    input  wire isa_pkg::word_t                           prog_data,
    // run control and status
    input  wire logic                                     start,
    output wire logic [`NUM_CORES-1:0]                    core_done,
    output wire logic                                     all_done,
    output wire logic [`NUM_CORES*`WORD_W-1:0]            core_ac,
    output wire logic [`NUM_CORES*core_pkg::COUNT_W-1:0]  core_retired
);

    // per core instruction fetch
    wire isa_pkg::iaddr_t imem_raddr [`NUM_CORES];
    wire isa_pkg::word_t  imem_rdata [`NUM_CORES];

    // status buses into the result block, indexed by core id
    retire_if ret_bus [`NUM_CORES] ();

    instr_mem u_imem (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (imem_raddr),
        .rdata (imem_rdata)
    );

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
        // private decode to execute link
        issue_if iss ();

        core_decode u_decode (
            .clk   (clk),
            .reset (reset),
            .start (start),
            .rdata (imem_rdata[i]),
            .raddr (imem_raddr[i]),
            .iss   (iss)
        );

        // the id is the only difference between cores
        core_execute #(
            .CORE_ID (core_pkg::core_id_t'(i))
        ) u_execute (
            .clk   (clk),
            .reset (reset),
            .start (start),
            .iss   (iss),
            .ret   (ret_bus[i])
        );
    end

    core_result u_result (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .ret          (ret_bus),
        .core_done    (core_done),
        .all_done     (all_done),
        .core_ac      (core_ac),
        .core_retired (core_retired)
    );

endmodule

`default_nettype wire

/* hw/proc_config.svh */
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// cores, which is also the number of instruction memory read ports
`define NUM_CORES 4

// data and instruction width
`define WORD_W 16

// shared program store, in words
`define IMEM_DEPTH 256

// private data memory per core, in words
`define DMEM_DEPTH 16

`endif
